// ==== audio_mixer.sv ====
// Saturating stereo mixer
`timescale 1ns/1ps

module audio_mixer (
	input  logic              clk_sys,
	input  logic              RESET,
	input  cart_pkg::sample_t main_l,
	input  cart_pkg::sample_t main_r,
	input  cart_pkg::sample_t msu_l,
	input  cart_pkg::sample_t msu_r,
	output cart_pkg::sample_t audio_l,
	output cart_pkg::sample_t audio_r
);

	// Sum in 17 bits, clamp when the top two bits disagree
	function automatic cart_pkg::sample_t sat_add(
		input cart_pkg::sample_t a,
		input cart_pkg::sample_t b
	);
		logic [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		if (sum[16] != sum[15])
			sat_add = {sum[16], {15{sum[15]}}};
		else
			sat_add = sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= sat_add(main_l, msu_l);
			audio_r <= sat_add(main_r, msu_r);
		end
	end

endmodule

// ==== cart_loader_asserts.sv ====
// Load control assertions
`timescale 1ns/1ps

module cart_loader_asserts (
	input logic clk_sys,
	input logic RESET,
	input logic fill_start,
	input logic fill_busy,
	input logic sys_hold,
	input logic cart_wr,
	input logic code_wr
);

	// RAM clear starts from a single pulse
	start_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_start |=> !fill_start)
		else $error("fill_start high for more than one cycle");

	hold_follows_fill: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_busy |=> sys_hold)
		else $error("sys_hold low on the cycle after fill_busy");

	// Only one download kind at a time
	one_writer: assert property (@(posedge clk_sys) disable iff (RESET)
		!(cart_wr && code_wr))
		else $error("cart_wr and code_wr high together");

endmodule

bind load_ctrl cart_loader_asserts u_asserts (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.fill_start (fill_start),
	.fill_busy  (fill_busy),
	.sys_hold   (sys_hold),
	.cart_wr    (cart_wr),
	.code_wr    (code_wr)
);

// ==== cart_loader_tb.sv ====
// Cartridge loader testbench
`timescale 1ns/1ps

module cart_loader_tb;

	localparam int FILL_BITS      = 10;
	localparam int FILL_WORDS     = 1 << FILL_BITS;
	localparam int NUM_FILLS      = 9;
	localparam int AUDIO_RANDOM   = 200;
	localparam int TIMEOUT_CYCLES = NUM_FILLS * (FILL_WORDS + 20) + AUDIO_RANDOM + 500;
	// Saturation corner cases, upper half plus lower half
	localparam logic [4:0][31:0] EDGE_PAIRS = {32'h7FFF_7FFF, 32'h8000_8000,
		32'h7FFF_0001, 32'h8000_FFFF, 32'h7FFF_8000};

	logic                   clk_sys;
	logic                   RESET;
	logic                   dl_active;
	cart_pkg::dl_index_t    dl_index;
	cart_pkg::dl_addr_t     dl_addr;
	cart_pkg::dl_data_t     dl_data;
	logic                   dl_wr;
	cart_pkg::header_mode_t header_mode;
	logic [1:0]             region_sel;
	logic [1:0]             fill_pattern_sel;
	cart_pkg::sample_t      main_l;
	cart_pkg::sample_t      main_r;
	cart_pkg::sample_t      msu_l;
	cart_pkg::sample_t      msu_r;
	cart_pkg::rom_type_t    rom_type;
	cart_pkg::mem_mask_t    rom_mask;
	cart_pkg::mem_mask_t    ram_mask;
	logic                   pal;
	cart_pkg::cheat_code_t  code_word;
	logic                   code_valid;
	logic                   code_clear;
	logic [FILL_BITS-1:0]   fill_addr;
	cart_pkg::fill_data_t   fill_data;
	logic                   fill_wr;
	logic                   sys_hold;
	cart_pkg::sample_t      audio_l;
	cart_pkg::sample_t      audio_r;

	integer             seed;
	int                 fill_count;
	int                 fills_done;
	int                 valid_count;
	logic               mix_valid;
	cart_pkg::sample_t  prev_main_l;
	cart_pkg::sample_t  prev_main_r;
	cart_pkg::sample_t  prev_msu_l;
	cart_pkg::sample_t  prev_msu_r;
	logic [31:0]        r;
	logic [31:0]        r2;
	logic [7:0]         size_byte;
	logic [7:0][15:0]   cheat_words;
	cart_pkg::dl_addr_t hdr_base;

	cart_loader_top #(.FILL_ADDR_BITS(FILL_BITS)) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ====================
	// Reference model
	// ====================
	function automatic cart_pkg::mem_mask_t size_mask(input logic [3:0] code,
		input logic is_ram);
		logic [31:0] full;
		full = (32'd1 << (32'd10 + code)) - 32'd1;
		if (is_ram && (code == 4'd0))
			return '0;
		return full[23:0];
	endfunction

	function automatic cart_pkg::fill_data_t pattern_byte(input logic [1:0] sel,
		input logic [9:0] addr);
		case (sel)
			2'd0:    return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			2'd1:    return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic cart_pkg::sample_t saturated_sum(input cart_pkg::sample_t a,
		input cart_pkg::sample_t b);
		int s;
		s = int'(a) + int'(b);
		if (s > 32767)
			return 16'h7FFF;
		if (s < -32768)
			return 16'h8000;
		return s[15:0];
	endfunction

	// Flags on top, then address, compare, replace
	function automatic cart_pkg::cheat_code_t cheat_layout(input logic [7:0][15:0] w);
		return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
	endfunction

	task automatic check_equal(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("Error: %s expected %0h got %0h", name, exp, got);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// ====================
	// Stimulus helpers
	// ====================
	task automatic set_config(input cart_pkg::header_mode_t mode, input logic [1:0] rsel,
		input logic [1:0] psel);
		@(posedge clk_sys);
		header_mode      <= mode;
		region_sel       <= rsel;
		fill_pattern_sel <= psel;
	endtask

	task automatic start_load(input cart_pkg::dl_index_t idx);
		@(posedge clk_sys);
		dl_index  <= idx;
		dl_active <= 1'b1;
	endtask

	task automatic write_word(input cart_pkg::dl_addr_t addr, input cart_pkg::dl_data_t data);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
	endtask

	task automatic end_load();
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
	endtask

	task automatic cart_load(input cart_pkg::dl_data_t word0,
		input cart_pkg::dl_addr_t addr_a, input cart_pkg::dl_data_t data_a,
		input cart_pkg::dl_addr_t addr_b, input cart_pkg::dl_data_t data_b);
		int target;
		target = fills_done + 1;
		start_load(cart_pkg::IDX_CART);
		write_word('0, word0);
		@(negedge clk_sys);
		check_equal("code_clear", code_clear, 1'b1);
		write_word(addr_a, data_a);
		write_word(addr_b, data_b);
		end_load();
		// End of the RAM clear marks the load as done
		while (fills_done < target)
			@(posedge clk_sys);
	endtask

	// ====================
	// Compare process
	// ====================
	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (fill_wr) begin
				check_equal("fill_addr", fill_addr, fill_count);
				check_equal("fill_data", fill_data, pattern_byte(fill_pattern_sel, fill_addr));
				check_equal("sys_hold", sys_hold, 1'b1);
				fill_count++;
			end else if (fill_count != 0) begin
				check_equal("fill_length", fill_count, FILL_WORDS);
				fill_count = 0;
				fills_done++;
			end
			if (code_valid)
				valid_count++;
			if (mix_valid) begin
				check_equal("audio_l", {audio_l}, {saturated_sum(prev_main_l, prev_msu_l)});
				check_equal("audio_r", {audio_r}, {saturated_sum(prev_main_r, prev_msu_r)});
			end
		end
		prev_main_l = main_l;
		prev_main_r = main_r;
		prev_msu_l  = msu_l;
		prev_msu_r  = msu_r;
		mix_valid   = !RESET;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$fatal(1);
	end

	initial begin
		seed             = 32'h2f787492;
		fill_count       = 0;
		fills_done       = 0;
		valid_count      = 0;
		mix_valid        = 1'b0;
		RESET            = 1'b1;
		dl_active        = 1'b0;
		dl_index         = '0;
		dl_addr          = '0;
		dl_data          = '0;
		dl_wr            = 1'b0;
		header_mode      = cart_pkg::HDR_AUTO;
		region_sel       = 2'd0;
		fill_pattern_sel = 2'd0;
		main_l           = '0;
		main_r           = '0;
		msu_l            = '0;
		msu_r            = '0;
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_equal("fill_wr", fill_wr, 1'b0);
		check_equal("code_valid", code_valid, 1'b0);
		check_equal("code_clear", code_clear, 1'b0);
		check_equal("sys_hold", sys_hold, 1'b0);
		check_equal("rom_type", rom_type, 8'h00);
		check_equal("rom_mask", rom_mask, size_mask(4'd0, 1'b0));
		check_equal("ram_mask", ram_mask, 24'h0);

		// Auto mode header from the size word, then forced region
		r = $random(seed);
		size_byte = (r[7:0] == 8'h00) ? 8'h21 : r[7:0];
		set_config(cart_pkg::HDR_AUTO, 2'd0, 2'd0);
		cart_load({r[15:8], size_byte}, 25'd2, {7'd0, r[16], 8'h00}, 25'd4, r[31:16]);
		check_equal("rom_type", rom_type, r[15:8]);
		check_equal("rom_mask", rom_mask, size_mask(size_byte[3:0], 1'b0));
		check_equal("ram_mask", ram_mask, size_mask(size_byte[7:4], 1'b1));
		check_equal("pal", pal, r[16]);
		set_config(cart_pkg::HDR_AUTO, 2'd2, 2'd0);
		cart_load(16'h0000, 25'd2, 16'h0000, 25'd4, 16'h0000);
		check_equal("pal", pal, 1'b1);
		// Zero size byte falls back to the default sizes
		check_equal("rom_mask", rom_mask, size_mask(4'd12, 1'b0));
		check_equal("ram_mask", ram_mask, 24'h0);

		// Internal header in the three forced layouts
		for (int m = 0; m < 3; m++) begin
			r  = $random(seed);
			r2 = $random(seed);
			case (m)
				0:       hdr_base = cart_pkg::LOROM_HDR_BASE;
				1:       hdr_base = cart_pkg::HIROM_HDR_BASE;
				default: hdr_base = cart_pkg::EXHIROM_HDR_BASE;
			endcase
			set_config(cart_pkg::header_mode_t'(m + 2), 2'd0, 2'd0);
			cart_load(r[15:0], hdr_base + 25'd512, r[31:16], hdr_base + 25'd514, r2[15:0]);
			check_equal("rom_type", rom_type, m);
			check_equal("rom_mask", rom_mask, size_mask(r[27:24], 1'b0));
			check_equal("ram_mask", ram_mask, size_mask(r2[3:0], 1'b1));
		end

		// RAM clear with every pattern, checked by the compare process
		for (int p = 0; p < 4; p++) begin
			r = $random(seed);
			set_config(cart_pkg::HDR_AUTO, 2'd0, p[1:0]);
			cart_load(r[15:0], 25'd2, r[31:16], 25'd4, 16'h0000);
		end

		// ====================
		// Cheat record
		// ====================
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			cheat_words[i] = r[15:0];
		end
		start_load(cart_pkg::IDX_CODE);
		for (int i = 0; i < 8; i++) begin
			write_word(cart_pkg::dl_addr_t'(2 * i), cheat_words[i]);
			@(negedge clk_sys);
			check_equal("code_clear", code_clear, (i == 0));
		end
		end_load();
		@(negedge clk_sys);
		while (code_valid !== 1'b1)
			@(negedge clk_sys);
		check_equal("code_word", code_word, cheat_layout(cheat_words));
		@(negedge clk_sys);
		check_equal("code_valid", code_valid, 1'b0);

		// Audio, random then the saturation corners
		for (int i = 0; i < AUDIO_RANDOM; i++) begin
			r  = $random(seed);
			r2 = $random(seed);
			@(posedge clk_sys);
			main_l <= r[15:0];
			msu_l  <= r[31:16];
			main_r <= r2[15:0];
			msu_r  <= r2[31:16];
		end
		for (int i = 0; i < 5; i++) begin
			@(posedge clk_sys);
			main_l <= EDGE_PAIRS[i][31:16];
			msu_l  <= EDGE_PAIRS[i][15:0];
			main_r <= EDGE_PAIRS[i][15:0];
			msu_r  <= EDGE_PAIRS[i][31:16];
		end
		@(posedge clk_sys);
		main_l <= '0;
		main_r <= '0;
		msu_l  <= '0;
		msu_r  <= '0;
		repeat (2) @(negedge clk_sys);

		check_equal("code_valid_pulses", valid_count, 1);
		check_equal("fill_runs", fills_done, NUM_FILLS);
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== cart_loader_top.f ====
cart_pkg.sv
load_ctrl.sv
rom_header_detect.sv
cheat_code_assembler.sv
wram_fill_gen.sv
audio_mixer.sv
cart_loader_top.sv
cart_loader_asserts.sv
cart_loader_tb.sv

// ==== cart_loader_top.sv ====
// Cartridge loader top level
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      dl_active,
	input  cart_pkg::dl_index_t       dl_index,
	input  cart_pkg::dl_addr_t        dl_addr,
	input  cart_pkg::dl_data_t        dl_data,
	input  logic                      dl_wr,
	input  cart_pkg::header_mode_t    header_mode,
	input  logic [1:0]                region_sel,
	input  logic [1:0]                fill_pattern_sel,
	input  cart_pkg::sample_t         main_l,
	input  cart_pkg::sample_t         main_r,
	input  cart_pkg::sample_t         msu_l,
	input  cart_pkg::sample_t         msu_r,
	output cart_pkg::rom_type_t       rom_type,
	output cart_pkg::mem_mask_t       rom_mask,
	output cart_pkg::mem_mask_t       ram_mask,
	output logic                      pal,
	output cart_pkg::cheat_code_t     code_word,
	output logic                      code_valid,
	output logic                      code_clear,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output cart_pkg::fill_data_t      fill_data,
	output logic                      fill_wr,
	output logic                      sys_hold,
	output cart_pkg::sample_t         audio_l,
	output cart_pkg::sample_t         audio_r
);

	logic cart_active;
	logic cart_wr;
	logic code_wr;
	logic fill_start;
	logic fill_busy;

	// ====================
	// Download control
	// ====================
	load_ctrl u_ctrl (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_wr       (dl_wr),
		.fill_busy   (fill_busy),
		.cart_active (cart_active),
		.cart_wr     (cart_wr),
		.code_wr     (code_wr),
		.fill_start  (fill_start),
		.code_clear  (code_clear),
		.sys_hold    (sys_hold)
	);

	rom_header_detect u_header (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_active (cart_active),
		.cart_wr     (cart_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_code_assembler u_cheat (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_wr    (code_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.code_word  (code_word),
		.code_valid (code_valid)
	);

	// ====================
	// RAM clear and audio
	// ====================
	wram_fill_gen #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) u_fill (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.fill_start       (fill_start),
		.fill_pattern_sel (fill_pattern_sel),
		.fill_addr        (fill_addr),
		.fill_data        (fill_data),
		.fill_wr          (fill_wr),
		.fill_busy        (fill_busy)
	);

	audio_mixer u_mix (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.main_l  (main_l),
		.main_r  (main_r),
		.msu_l   (msu_l),
		.msu_r   (msu_r),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

// ==== cart_pkg.sv ====
// Cartridge loader shared definitions
package cart_pkg;

	// ====================
	// Vector types
	// ====================
	typedef logic [24:0]        dl_addr_t;
	typedef logic [15:0]        dl_data_t;
	typedef logic [7:0]         dl_index_t;
	typedef logic [23:0]        mem_mask_t;
	typedef logic [3:0]         size_code_t;
	typedef logic [7:0]         rom_type_t;
	typedef logic [2:0]         header_mode_t;
	typedef logic [127:0]       cheat_code_t;
	typedef logic [7:0]         fill_data_t;
	typedef logic signed [15:0] sample_t;

	// Header mode select
	localparam header_mode_t HDR_AUTO    = 3'd0;
	localparam header_mode_t HDR_NONE    = 3'd1;
	localparam header_mode_t HDR_LOROM   = 3'd2;
	localparam header_mode_t HDR_HIROM   = 3'd3;
	localparam header_mode_t HDR_EXHIROM = 3'd4;

	// ====================
	// Download index codes
	// ====================
	// Cartridge and sound program compare on the low six bits only
	localparam dl_index_t IDX_CART = 8'h00;
	localparam dl_index_t IDX_SPC  = 8'h01;
	localparam dl_index_t IDX_CODE = 8'hFF;

	// ROM header layout
	localparam dl_addr_t   HEADER_SKIP      = 25'd512;
	localparam size_code_t ROM_SIZE_DEFAULT = 4'd12;
	localparam dl_addr_t   LOROM_HDR_BASE   = 25'h0007FD6;
	localparam dl_addr_t   HIROM_HDR_BASE   = 25'h000FFD6;
	localparam dl_addr_t   EXHIROM_HDR_BASE = 25'h040FFD6;

	// Work RAM power-on patterns
	localparam logic [1:0] PATTERN_FILL_SNES2 = 2'd0;
	localparam logic [1:0] PATTERN_FILL_SNES1 = 2'd1;
	localparam logic [1:0] PATTERN_FILL_55    = 2'd2;
	localparam logic [1:0] PATTERN_FILL_FF    = 2'd3;

endpackage

// ==== cheat_code_assembler.sv ====
// Cheat record assembler
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_wr,
	input  cart_pkg::dl_addr_t    dl_addr,
	input  cart_pkg::dl_data_t    dl_data,
	output cart_pkg::cheat_code_t code_word,
	output logic                  code_valid
);

	// Record layout, flags 127:96, address 95:64, compare 63:32, replace 31:0
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  code_word[111:96]  <= dl_data;
				4'd2:  code_word[127:112] <= dl_data;
				4'd4:  code_word[79:64]   <= dl_data;
				4'd6:  code_word[95:80]   <= dl_data;
				4'd8:  code_word[47:32]   <= dl_data;
				4'd10: code_word[63:48]   <= dl_data;
				4'd12: code_word[15:0]    <= dl_data;
				4'd14: code_word[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word of the record completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (dl_addr[3:0] == 4'd14);
	end

endmodule

// ==== load_ctrl.sv ====
// Download decode and system hold
`timescale 1ns/1ps

module load_ctrl (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::dl_addr_t  dl_addr,
	input  logic                dl_wr,
	input  logic                fill_busy,
	output logic                cart_active,
	output logic                cart_wr,
	output logic                code_wr,
	output logic                fill_start,
	output logic                code_clear,
	output logic                sys_hold
);

	logic cart_dl;
	logic spc_dl;
	logic code_dl;
	logic cart_dl_prev;

	// ====================
	// Download kind
	// ====================
	assign cart_dl = dl_active && (dl_index[5:0] == cart_pkg::IDX_CART[5:0]);
	assign spc_dl  = dl_active && (dl_index[5:0] == cart_pkg::IDX_SPC[5:0]);
	assign code_dl = dl_active && (dl_index == cart_pkg::IDX_CODE);

	assign cart_active = cart_dl;
	assign cart_wr     = cart_dl && dl_wr;
	assign code_wr     = code_dl && dl_wr;

	// Rising edge of the cartridge load kicks off the RAM clear
	assign fill_start = cart_dl && !cart_dl_prev;

	// Cheat table is flushed by a new cheat file or any cartridge load
	assign code_clear = (code_wr && (dl_addr == '0)) || cart_dl;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_prev <= 1'b0;
			sys_hold     <= 1'b0;
		end else begin
			cart_dl_prev <= cart_dl;
			// Hold for every known download kind and while RAM is cleared
			sys_hold     <= cart_dl || spc_dl || code_dl || fill_busy;
		end
	end

endmodule

// ==== rom_header_detect.sv ====
// ROM header parser
`timescale 1ns/1ps

module rom_header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_active,
	input  logic                   cart_wr,
	input  cart_pkg::dl_addr_t     dl_addr,
	input  cart_pkg::dl_data_t     dl_data,
	input  cart_pkg::header_mode_t header_mode,
	input  logic [1:0]             region_sel,
	output cart_pkg::rom_type_t    rom_type,
	output cart_pkg::mem_mask_t    rom_mask,
	output cart_pkg::mem_mask_t    ram_mask,
	output logic                   pal
);

	cart_pkg::size_code_t rom_size;
	cart_pkg::size_code_t ram_size;
	logic                 rom_region;
	logic                 hdr_en;
	cart_pkg::dl_addr_t   hdr_base;
	cart_pkg::dl_addr_t   rom_size_addr;
	cart_pkg::dl_addr_t   ram_size_addr;

	// Internal header location for the forced modes
	always_comb begin
		hdr_en   = 1'b1;
		hdr_base = cart_pkg::LOROM_HDR_BASE;
		case (header_mode)
			cart_pkg::HDR_LOROM:   hdr_base = cart_pkg::LOROM_HDR_BASE;
			cart_pkg::HDR_HIROM:   hdr_base = cart_pkg::HIROM_HDR_BASE;
			cart_pkg::HDR_EXHIROM: hdr_base = cart_pkg::EXHIROM_HDR_BASE;
			default:               hdr_en = 1'b0;
		endcase
	end

	// Header sits behind the copier header in the stream
	assign rom_size_addr = hdr_base + cart_pkg::HEADER_SKIP;
	assign ram_size_addr = rom_size_addr + 25'd2;

	// ====================
	// Header capture
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= '0;
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (cart_wr) begin
				if (dl_addr == '0) begin
					rom_size <= cart_pkg::ROM_SIZE_DEFAULT;
					ram_size <= '0;
					// Loader puts the size byte in front of the image in auto mode
					if ((header_mode == cart_pkg::HDR_AUTO) && (dl_data[7:0] != '0)) begin
						ram_size <= dl_data[7:4];
						rom_size <= dl_data[3:0];
					end
					case (header_mode)
						cart_pkg::HDR_NONE:    rom_type <= 8'd0;
						cart_pkg::HDR_LOROM:   rom_type <= 8'd0;
						cart_pkg::HDR_HIROM:   rom_type <= 8'd1;
						cart_pkg::HDR_EXHIROM: rom_type <= 8'd2;
						default:               rom_type <= dl_data[15:8];
					endcase
				end
				if (dl_addr == 25'd2)
					rom_region <= dl_data[8];
				if (hdr_en && (dl_addr == rom_size_addr))
					rom_size <= dl_data[11:8];
				if (hdr_en && (dl_addr == ram_size_addr))
					ram_size <= dl_data[3:0];
			end
			// Region select 0 means follow the cartridge
			if (!cart_active)
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	assign rom_mask = (24'd1024 << rom_size) - 24'd1;
	assign ram_mask = (ram_size != '0) ? ((24'd1024 << ram_size) - 24'd1) : 24'd0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cart_loader_tb -f cart_loader_top.f
./obj_dir/Vcart_loader_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi

// ==== wram_fill_gen.sv ====
// Work RAM clear generator
`timescale 1ns/1ps

module wram_fill_gen #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      fill_start,
	input  logic [1:0]                fill_pattern_sel,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output cart_pkg::fill_data_t      fill_data,
	output logic                      fill_wr,
	output logic                      fill_busy
);

	typedef enum logic {
		FILL_IDLE,
		FILL_RUN
	} fill_state_t;

	fill_state_t state;

	// ====================
	// Address sweep
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= FILL_IDLE;
			fill_addr <= '0;
		end else begin
			case (state)
				FILL_IDLE: begin
					fill_addr <= '0;
					if (fill_start)
						state <= FILL_RUN;
				end
				FILL_RUN: begin
					fill_addr <= fill_addr + 1'b1;
					if (&fill_addr)
						state <= FILL_IDLE;
				end
				default: state <= FILL_IDLE;
			endcase
		end
	end

	assign fill_wr   = (state == FILL_RUN);
	assign fill_busy = fill_wr;

	// Power-on contents of the different console revisions
	always_comb begin
		case (fill_pattern_sel)
			cart_pkg::PATTERN_FILL_SNES2:
				fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::PATTERN_FILL_SNES1:
				fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::PATTERN_FILL_55:
				fill_data = 8'h55;
			default:
				fill_data = 8'hFF;
		endcase
	end

endmodule
